// File: logic/encoderPkg.sv
package encoderPkg;

	//////////////////////////////
	// Stage units

	localparam int stageCount = 16;

	typedef enum logic [3:0] {
		stageAutocorr,
		stageLagWindow,
		stageLevinson,
		stageAzToLsp,
		stageLspQuantizer,
		stageLpcInterp,
		stageQlpcInterp,
		stageFrameMath1,
		stagePercVar,
		stageWeightAz,
		stageResidual,
		stageSynthFilter,
		stagePitchOpenLoop,
		stageFrameMath2,
		stageSubframeMath3,
		stagePitchFraction
	} stageId_t;

	typedef logic [stageCount-1:0] stageMask_t;     // One bit per stage unit

	//////////////////////////////
	// Datapath registers

	localparam int regCount = 9;

	typedef enum logic [3:0] {
		regPitchOpenLoop,
		regPitchMin,
		regPitchMax,
		regLpcAddr,
		regQlpcAddr,
		regGammaIndex,
		regSubframeIndex,
		regPitchInt,
		regPitchFrac
	} coderReg_t;

	typedef logic [regCount-1:0] regMask_t;         // Load or clear strobe per register

	//////////////////////////////
	// Arithmetic mux and framing

	typedef logic [4:0] muxStep_t;                  // Steps 0 to 29
	typedef logic [15:0] subframeIndex_t;

	localparam subframeIndex_t frameLength = 16'd80;        // Samples per frame
	localparam logic [1:0] framesPerAnalysis = 2'd2;
	localparam muxStep_t loopFirstStep = 5'd19;             // Steps below belong to the frame level

	//////////////////////////////
	// State machines

	typedef enum logic [1:0] {
		lpcIdle,
		lpcWaitFrame,
		lpcBusy,
		lpcPairGap
	} lpcState_t;

	typedef enum logic [2:0] {
		sfIdle,
		sfTest,
		sfBusy,
		sfPairGap,
		sfAdvance,
		sfDone
	} subframeState_t;

	typedef enum logic {
		gateIdle,
		gateArmed
	} gateState_t;

endpackage

// File: logic/frameArrivalGate.sv
module frameArrivalGate
(
	input logic clock,
	input logic reset,
	input logic start,
	input logic frameDone,
	output logic frameReady
);

	encoderPkg::gateState_t state;
	encoderPkg::gateState_t nextState;
	logic [1:0] frameCount;                 // Frame-done pulses since the last release
	logic armed;

	assign armed = (state == encoderPkg::gateArmed);

	// Release autocorrelation once a full analysis window has arrived
	assign frameReady = armed && (frameCount == encoderPkg::framesPerAnalysis);

	always_comb
	begin
		nextState = state;
		case (state)
			encoderPkg::gateIdle:
			begin
				if (start)
					nextState = encoderPkg::gateArmed;      // First start arms for good
			end
			encoderPkg::gateArmed:
			begin
				nextState = encoderPkg::gateArmed;
			end
			default:
			begin
				nextState = encoderPkg::gateIdle;
			end
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			state <= encoderPkg::gateIdle;
		else
			state <= nextState;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			frameCount <= 2'd0;
		else if (frameReady)
			frameCount <= 2'd0;                     // A pulse in this cycle is dropped
		else if (armed && frameDone)
			frameCount <= frameCount + 2'd1;
	end

	countBound: assert property (@(posedge clock) disable iff (reset)
		frameCount <= encoderPkg::framesPerAnalysis);

endmodule

// File: logic/lpcAnalysisSequencer.sv
module lpcAnalysisSequencer
(
	input logic clock,
	input logic reset,
	input logic start,
	input logic divErr,
	input logic frameReady,
	input encoderPkg::stageMask_t stageDone,
	output encoderPkg::stageMask_t stageStart,
	output encoderPkg::muxStep_t mathMuxSel,
	output encoderPkg::regMask_t regLoad,
	output encoderPkg::regMask_t regClear,
	output logic loopStart
);

	encoderPkg::lpcState_t state;
	encoderPkg::lpcState_t nextState;
	encoderPkg::muxStep_t stepReg;           // Step of the call in flight
	encoderPkg::muxStep_t nextStep;
	encoderPkg::muxStep_t followStep;
	encoderPkg::stageId_t waitStage;
	encoderPkg::stageId_t followStage;

	//////////////////////////////
	// Frame-level call order

	// Each mux step names one stage call
	function automatic encoderPkg::stageId_t stageOf(input encoderPkg::muxStep_t step);
		case (step)
			5'd0: return encoderPkg::stageAutocorr;
			5'd1: return encoderPkg::stageLagWindow;
			5'd2: return encoderPkg::stageLevinson;
			5'd3: return encoderPkg::stageAzToLsp;
			5'd4: return encoderPkg::stageLspQuantizer;
			5'd5: return encoderPkg::stageLpcInterp;
			5'd6: return encoderPkg::stageQlpcInterp;
			5'd7: return encoderPkg::stageFrameMath1;
			5'd8: return encoderPkg::stagePercVar;
			5'd9, 5'd10: return encoderPkg::stageWeightAz;
			5'd11: return encoderPkg::stageResidual;
			5'd12: return encoderPkg::stageSynthFilter;
			5'd13, 5'd14: return encoderPkg::stageWeightAz;
			5'd15: return encoderPkg::stageResidual;
			5'd16: return encoderPkg::stageSynthFilter;
			5'd17: return encoderPkg::stagePitchOpenLoop;
			5'd18: return encoderPkg::stageFrameMath2;
			default: return encoderPkg::stagePitchFraction;     // Never called at frame level
		endcase
	endfunction

	assign followStep = stepReg + 5'd1;
	assign waitStage = stageOf(stepReg);
	assign followStage = stageOf(followStep);

	//////////////////////////////
	// Sequencing

	always_comb
	begin
		nextState = state;
		nextStep = stepReg;
		stageStart = '0;
		mathMuxSel = '0;
		regLoad = '0;
		regClear = '0;
		loopStart = 1'b0;
		case (state)
			encoderPkg::lpcIdle:
			begin
				if (start)
					nextState = encoderPkg::lpcWaitFrame;
				else
					regClear = '1;                          // Hold every register cleared
			end
			encoderPkg::lpcWaitFrame:
			begin
				if (frameReady)
				begin
					stageStart[encoderPkg::stageAutocorr] = 1'b1;
					nextStep = 5'd0;
					nextState = encoderPkg::lpcBusy;
				end
			end
			encoderPkg::lpcBusy:
			begin
				mathMuxSel = stepReg;                       // Held while the stage runs
				if (stageDone[waitStage])
				begin
					if (waitStage == encoderPkg::stageFrameMath2)
					begin
						regLoad[encoderPkg::regPitchMin] = 1'b1;
						regLoad[encoderPkg::regPitchMax] = 1'b1;
						regLoad[encoderPkg::regLpcAddr] = 1'b1;
						regLoad[encoderPkg::regQlpcAddr] = 1'b1;
						regClear[encoderPkg::regGammaIndex] = 1'b1;
						loopStart = 1'b1;                   // Hand off to the subframe loop
						nextState = encoderPkg::lpcIdle;
					end
					else if (followStage == waitStage)
					begin
						nextStep = followStep;              // Second call of a pair waits a cycle
						nextState = encoderPkg::lpcPairGap;
					end
					else
					begin
						nextStep = followStep;
						mathMuxSel = followStep;
						stageStart[followStage] = 1'b1;
					end
					if (waitStage == encoderPkg::stagePitchOpenLoop)
						regLoad[encoderPkg::regPitchOpenLoop] = 1'b1;
				end
			end
			encoderPkg::lpcPairGap:
			begin
				mathMuxSel = stepReg;
				stageStart[waitStage] = 1'b1;
				nextState = encoderPkg::lpcBusy;
			end
			default:
			begin
				nextState = encoderPkg::lpcIdle;
			end
		endcase
		if (divErr)
			nextState = encoderPkg::lpcIdle;            // Abort the frame
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= encoderPkg::lpcIdle;
			stepReg <= '0;
		end
		else
		begin
			state <= nextState;
			stepReg <= nextStep;
		end
	end

	startOneHot: assert property (@(posedge clock) disable iff (reset) $onehot0(stageStart));

	noLoopInIdle: assert property (@(posedge clock) disable iff (reset)
		(state == encoderPkg::lpcIdle && start) |-> !loopStart);

endmodule

// File: logic/subframeSequencer.sv
module subframeSequencer
(
	input logic clock,
	input logic reset,
	input logic divErr,
	input logic loopStart,
	input encoderPkg::subframeIndex_t subframeIndex,
	input encoderPkg::stageMask_t stageDone,
	output encoderPkg::stageMask_t stageStart,
	output encoderPkg::muxStep_t mathMuxSel,
	output encoderPkg::regMask_t regLoad,
	output encoderPkg::regMask_t regClear,
	output logic frameComplete
);

	encoderPkg::subframeState_t state;
	encoderPkg::subframeState_t nextState;
	encoderPkg::muxStep_t stepReg;
	encoderPkg::muxStep_t nextStep;
	encoderPkg::muxStep_t followStep;
	encoderPkg::stageId_t waitStage;
	encoderPkg::stageId_t followStage;

	//////////////////////////////
	// Subframe call order

	function automatic encoderPkg::stageId_t stageOf(input encoderPkg::muxStep_t step);
		case (step)
			5'd19, 5'd20: return encoderPkg::stageWeightAz;
			5'd21: return encoderPkg::stageSubframeMath3;
			5'd22, 5'd23: return encoderPkg::stageSynthFilter;
			5'd24: return encoderPkg::stageResidual;
			5'd25: return encoderPkg::stageSynthFilter;
			5'd26: return encoderPkg::stageResidual;
			5'd27: return encoderPkg::stageSynthFilter;
			5'd28: return encoderPkg::stagePitchFraction;
			default: return encoderPkg::stageAutocorr;      // Not part of the loop
		endcase
	endfunction

	assign followStep = stepReg + 5'd1;
	assign waitStage = stageOf(stepReg);
	assign followStage = stageOf(followStep);

	//////////////////////////////
	// Loop control

	always_comb
	begin
		nextState = state;
		nextStep = stepReg;
		stageStart = '0;
		mathMuxSel = '0;
		regLoad = '0;
		regClear = '0;
		frameComplete = 1'b0;
		case (state)
			encoderPkg::sfIdle:
			begin
				if (loopStart)
					nextState = encoderPkg::sfTest;
			end
			encoderPkg::sfTest:
			begin
				if (subframeIndex < encoderPkg::frameLength)
				begin
					mathMuxSel = encoderPkg::loopFirstStep;
					stageStart[stageOf(encoderPkg::loopFirstStep)] = 1'b1;
					nextStep = encoderPkg::loopFirstStep;
					nextState = encoderPkg::sfBusy;
				end
				else
				begin
					regClear[encoderPkg::regSubframeIndex] = 1'b1;     // Frame covered
					regClear[encoderPkg::regGammaIndex] = 1'b1;
					nextState = encoderPkg::sfDone;
				end
			end
			encoderPkg::sfBusy:
			begin
				mathMuxSel = stepReg;
				if (stageDone[waitStage])
				begin
					nextStep = followStep;
					if (waitStage == encoderPkg::stagePitchFraction)
					begin
						mathMuxSel = followStep;            // Shows the last step
						regLoad[encoderPkg::regSubframeIndex] = 1'b1;
						regLoad[encoderPkg::regPitchInt] = 1'b1;
						regLoad[encoderPkg::regPitchFrac] = 1'b1;
						nextState = encoderPkg::sfAdvance;
					end
					else if (followStage == waitStage)
						nextState = encoderPkg::sfPairGap;
					else
					begin
						mathMuxSel = followStep;
						stageStart[followStage] = 1'b1;
					end
					if (waitStage == encoderPkg::stageSubframeMath3)
						regLoad[encoderPkg::regGammaIndex] = 1'b1;
				end
			end
			encoderPkg::sfPairGap:
			begin
				mathMuxSel = stepReg;
				stageStart[waitStage] = 1'b1;
				nextState = encoderPkg::sfBusy;
			end
			encoderPkg::sfAdvance:
			begin
				// Step the filter coefficient pointers to the next subframe
				regLoad[encoderPkg::regLpcAddr] = 1'b1;
				regLoad[encoderPkg::regQlpcAddr] = 1'b1;
				nextState = encoderPkg::sfTest;
			end
			encoderPkg::sfDone:
			begin
				frameComplete = 1'b1;
				nextState = encoderPkg::sfIdle;
			end
			default:
			begin
				nextState = encoderPkg::sfIdle;
			end
		endcase
		if (divErr)
			nextState = encoderPkg::sfIdle;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= encoderPkg::sfIdle;
			stepReg <= '0;
		end
		else
		begin
			state <= nextState;
			stepReg <= nextStep;
		end
	end

	startOneHot: assert property (@(posedge clock) disable iff (reset) $onehot0(stageStart));

endmodule

// File: logic/encoderController.sv
module encoderController
(
	input logic clock,
	input logic reset,
	input logic start,
	input logic divErr,
	input logic frameDone,
	input encoderPkg::stageMask_t stageDone,
	input encoderPkg::subframeIndex_t subframeIndex,
	output encoderPkg::stageMask_t stageStart,
	output encoderPkg::muxStep_t mathMuxSel,
	output encoderPkg::regMask_t regLoad,
	output encoderPkg::regMask_t regClear,
	output logic frameComplete
);

	logic frameReady;
	logic loopStart;
	encoderPkg::stageMask_t lpcStageStart;
	encoderPkg::stageMask_t loopStageStart;
	encoderPkg::muxStep_t lpcMuxSel;
	encoderPkg::muxStep_t loopMuxSel;
	encoderPkg::regMask_t lpcRegLoad;
	encoderPkg::regMask_t loopRegLoad;
	encoderPkg::regMask_t lpcRegClear;
	encoderPkg::regMask_t loopRegClear;

	frameArrivalGate gate
	(
		.clock(clock),
		.reset(reset),
		.start(start),
		.frameDone(frameDone),
		.frameReady(frameReady)
	);

	lpcAnalysisSequencer lpcSeq
	(
		.clock(clock),
		.reset(reset),
		.start(start),
		.divErr(divErr),
		.frameReady(frameReady),
		.stageDone(stageDone),
		.stageStart(lpcStageStart),
		.mathMuxSel(lpcMuxSel),
		.regLoad(lpcRegLoad),
		.regClear(lpcRegClear),
		.loopStart(loopStart)
	);

	subframeSequencer loopSeq
	(
		.clock(clock),
		.reset(reset),
		.divErr(divErr),
		.loopStart(loopStart),
		.subframeIndex(subframeIndex),
		.stageDone(stageDone),
		.stageStart(loopStageStart),
		.mathMuxSel(loopMuxSel),
		.regLoad(loopRegLoad),
		.regClear(loopRegClear),
		.frameComplete(frameComplete)
	);

	// Idle sequencer drives zeros so a plain OR merges them
	assign stageStart = lpcStageStart | loopStageStart;
	assign mathMuxSel = lpcMuxSel | loopMuxSel;
	assign regLoad = lpcRegLoad | loopRegLoad;
	assign regClear = lpcRegClear | loopRegClear;

	singleOwner: assert property (@(posedge clock) disable iff (reset)
		!((|lpcStageStart) && (|loopStageStart)));

endmodule

// File: verif/stageModel.sv
module stageModel
(
	input logic clock,
	input logic reset,
	input logic randomDelays,
	input encoderPkg::stageMask_t stageStart,
	input encoderPkg::regMask_t regLoad,
	input encoderPkg::regMask_t regClear,
	output encoderPkg::stageMask_t stageDone,
	output encoderPkg::subframeIndex_t subframeIndex
);

	localparam int subframeLength = 40;           // Samples per subframe
	localparam int maxRandomDelay = 8;

	int fixedDelay [encoderPkg::stageCount];      // Cycles from start to done per stage
	int remaining [encoderPkg::stageCount];
	logic [encoderPkg::stageCount-1:0] busy;
	integer seed;
	logic resetSeen;
	logic randomSeen;
	encoderPkg::stageMask_t startSeen;
	encoderPkg::regMask_t loadSeen;
	encoderPkg::regMask_t clearSeen;

	initial
	begin
		seed = 32'h6c40;
		stageDone = '0;
		subframeIndex = '0;
		busy = '0;
		for (int i = 0; i < encoderPkg::stageCount; i++)
		begin
			fixedDelay[i] = i % 4;                    // Mix of immediate and late answers
			remaining[i] = 0;
		end
	end

	// Sample at the edge, answer one unit later
	always @(posedge clock)
	begin
		resetSeen = reset;
		randomSeen = randomDelays;
		startSeen = stageStart;
		loadSeen = regLoad;
		clearSeen = regClear;
		#1;
		stageDone = '0;                               // Done is a one-cycle pulse
		if (resetSeen)
		begin
			busy = '0;
			subframeIndex = '0;
		end
		else
		begin
			for (int i = 0; i < encoderPkg::stageCount; i++)
			begin
				if (startSeen[i])
				begin
					busy[i] = 1'b1;
					if (randomSeen)
						remaining[i] = int'({$random(seed)} % maxRandomDelay);
					else
						remaining[i] = fixedDelay[i];
				end
				if (busy[i])
				begin
					if (remaining[i] == 0)
					begin
						stageDone[i] = 1'b1;
						busy[i] = 1'b0;
					end
					else
						remaining[i] = remaining[i] - 1;
				end
			end
			if (clearSeen[encoderPkg::regSubframeIndex])
				subframeIndex = '0;
			else if (loadSeen[encoderPkg::regSubframeIndex])
				subframeIndex = subframeIndex + 16'(subframeLength);   // Next subframe
		end
	end

endmodule

// File: verif/encoderControllerTb.sv
module encoderControllerTb;

	localparam int subframeLength = 40;
	localparam int subframes = int'(encoderPkg::frameLength) / subframeLength;
	localparam int scenarioCount = 5;
	localparam int frameTimeout = 3000;           // Cycles
	localparam int idleCycles = 20;
	localparam encoderPkg::regMask_t allClear = '1;

	logic clock;
	logic reset;
	logic start;
	logic divErr;
	logic frameDone;
	logic randomDelays;
	encoderPkg::stageMask_t stageDone;
	encoderPkg::subframeIndex_t subframeIndex;
	encoderPkg::stageMask_t stageStart;
	encoderPkg::muxStep_t mathMuxSel;
	encoderPkg::regMask_t regLoad;
	encoderPkg::regMask_t regClear;
	logic frameComplete;

	logic scenarioRandom [scenarioCount];         // Random stage delays for this frame
	int scenarioAbortRow [scenarioCount];         // divErr after this start row, -1 for none
	encoderPkg::stageId_t expStage [$];
	encoderPkg::muxStep_t expStep [$];

	int rowIdx;
	int completeCount;
	int loadCount [encoderPkg::regCount];
	int clearCount [encoderPkg::regCount];
	int framesCompleted;                          // frameComplete pulses over the whole run
	int framesExpected;
	logic outstanding;
	logic checkHold;
	encoderPkg::muxStep_t heldStep;
	encoderPkg::stageId_t heldStage;

	encoderController uut
	(
		.clock(clock),
		.reset(reset),
		.start(start),
		.divErr(divErr),
		.frameDone(frameDone),
		.stageDone(stageDone),
		.subframeIndex(subframeIndex),
		.stageStart(stageStart),
		.mathMuxSel(mathMuxSel),
		.regLoad(regLoad),
		.regClear(regClear),
		.frameComplete(frameComplete)
	);

	stageModel stages
	(
		.clock(clock),
		.reset(reset),
		.randomDelays(randomDelays),
		.stageStart(stageStart),
		.regLoad(regLoad),
		.regClear(regClear),
		.stageDone(stageDone),
		.subframeIndex(subframeIndex)
	);

	always #4 clock = ~clock;

	//////////////////////////////
	// Helpers

	task automatic stopWithError(input string what);
		$display("ERROR at time %0t: %s", $time, what);
		$display("Verification failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
		begin
			$display("CHECK FAILED at time %0t: %s (got %0h, expected %0h)",
				$time, what, actual, expected);
			$display("Verification failed");
			$fatal(1, "stopping at first error");
		end
	endtask

	task automatic advanceCycle();
		@(posedge clock);
		#1;
	endtask

	function automatic encoderPkg::stageMask_t maskOf(input encoderPkg::stageId_t stage);
		encoderPkg::stageMask_t mask;
		mask = '0;
		mask[stage] = 1'b1;
		return mask;
	endfunction

	function automatic int expectedLoads(input int r);
		if (r == int'(encoderPkg::regLpcAddr) || r == int'(encoderPkg::regQlpcAddr))
			return 1 + subframes;                 // Frame setup plus one step per subframe
		else if (r <= int'(encoderPkg::regPitchMax))
			return 1;
		else
			return subframes;
	endfunction

	function automatic int expectedClears(input int r);
		if (r == int'(encoderPkg::regGammaIndex))
			return 2;                             // Loop handoff and end of frame
		else if (r == int'(encoderPkg::regSubframeIndex))
			return 1;
		else
			return 0;
	endfunction

	task automatic addCall(input encoderPkg::stageId_t stage, input int step);
		expStage.push_back(stage);
		expStep.push_back(encoderPkg::muxStep_t'(step));
	endtask

	task automatic buildTables();
		scenarioRandom = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b0};
		scenarioAbortRow = '{-1, -1, -1, 24, -1};
		addCall(encoderPkg::stageAutocorr, 0);
		addCall(encoderPkg::stageLagWindow, 1);
		addCall(encoderPkg::stageLevinson, 2);
		addCall(encoderPkg::stageAzToLsp, 3);
		addCall(encoderPkg::stageLspQuantizer, 4);
		addCall(encoderPkg::stageLpcInterp, 5);
		addCall(encoderPkg::stageQlpcInterp, 6);
		addCall(encoderPkg::stageFrameMath1, 7);
		addCall(encoderPkg::stagePercVar, 8);
		addCall(encoderPkg::stageWeightAz, 9);
		addCall(encoderPkg::stageWeightAz, 10);
		addCall(encoderPkg::stageResidual, 11);
		addCall(encoderPkg::stageSynthFilter, 12);
		addCall(encoderPkg::stageWeightAz, 13);
		addCall(encoderPkg::stageWeightAz, 14);
		addCall(encoderPkg::stageResidual, 15);
		addCall(encoderPkg::stageSynthFilter, 16);
		addCall(encoderPkg::stagePitchOpenLoop, 17);
		addCall(encoderPkg::stageFrameMath2, 18);
		for (int sub = 0; sub < subframes; sub++)
		begin
			addCall(encoderPkg::stageWeightAz, 19);
			addCall(encoderPkg::stageWeightAz, 20);
			addCall(encoderPkg::stageSubframeMath3, 21);
			addCall(encoderPkg::stageSynthFilter, 22);
			addCall(encoderPkg::stageSynthFilter, 23);
			addCall(encoderPkg::stageResidual, 24);
			addCall(encoderPkg::stageSynthFilter, 25);
			addCall(encoderPkg::stageResidual, 26);
			addCall(encoderPkg::stageSynthFilter, 27);
			addCall(encoderPkg::stagePitchFraction, 28);
		end
		framesExpected = 0;
		for (int s = 0; s < scenarioCount; s++)
			if (scenarioAbortRow[s] < 0)
				framesExpected++;
	endtask

	//////////////////////////////
	// Start order and mux monitor

	always @(negedge clock)
	begin
		if (!reset)
		begin
			if (stageStart != '0)
			begin
				if (rowIdx >= expStage.size())
					stopWithError("stage start beyond the end of the frame");
				if (checkHold && outstanding && !stageDone[heldStage])
					stopWithError("stage started while the previous stage was busy");
				checkValue(32'(stageStart), 32'(maskOf(expStage[rowIdx])),
					$sformatf("stage started at row %0d", rowIdx));
				checkValue(32'(mathMuxSel), 32'(expStep[rowIdx]),
					$sformatf("mux step at row %0d", rowIdx));
				heldStep = mathMuxSel;
				heldStage = expStage[rowIdx];
				outstanding = 1'b1;
				rowIdx++;
			end
			else if (outstanding)
			begin
				if (stageDone[heldStage])
					outstanding = 1'b0;
				else if (checkHold)
					checkValue(32'(mathMuxSel), 32'(heldStep), "mux step held while busy");
			end
			for (int r = 0; r < encoderPkg::regCount; r++)
			begin
				if (regLoad[r])
					loadCount[r]++;
				if (regClear[r])
					clearCount[r]++;
			end
			if (frameComplete)
			begin
				completeCount++;
				framesCompleted++;
			end
		end
	end

	//////////////////////////////
	// Frame runs

	task automatic finishFrame();
		int cycles;
		cycles = 0;
		while (completeCount == 0)
		begin
			@(posedge clock);
			cycles++;
			if (cycles > frameTimeout)
				stopWithError("timeout while waiting for frameComplete");
		end
		repeat (4) @(posedge clock);
		checkValue(32'(completeCount), 32'd1, "frameComplete pulses per frame");
		checkValue(32'(rowIdx), 32'(expStage.size()), "stage starts per frame");
		for (int r = 0; r < encoderPkg::regCount; r++)
			checkValue(32'(loadCount[r]), 32'(expectedLoads(r)),
				$sformatf("load count of register %0d", r));
		for (int r = 0; r < encoderPkg::regCount; r++)
			checkValue(32'(clearCount[r]), 32'(expectedClears(r)),
				$sformatf("clear count of register %0d", r));
	endtask

	task automatic abortFrame(input int row);
		int cycles;
		cycles = 0;
		while (rowIdx <= row)
		begin
			@(posedge clock);
			cycles++;
			if (cycles > frameTimeout)
				stopWithError("timeout while waiting for the abort point");
		end
		#1;
		checkHold = 1'b0;                             // Mux drops to zero on abort
		divErr = 1'b1;
		advanceCycle();
		divErr = 1'b0;
		start = 1'b0;
		repeat (idleCycles)
		begin
			@(negedge clock);
			checkValue(32'(stageStart), 32'd0, "no stage start after divErr");
		end
		checkValue(32'(regClear), 32'(allClear), "all registers cleared in idle");
		checkValue(32'(mathMuxSel), 32'd0, "mux step in idle");
		checkValue(32'(subframeIndex), 32'd0, "subframe index cleared in idle");
		@(posedge clock);
		checkValue(32'(completeCount), 32'd0, "no frameComplete after divErr");
	endtask

	task automatic runFrame(input int s);
		advanceCycle();
		randomDelays = scenarioRandom[s];
		start = 1'b1;
		rowIdx = 0;
		completeCount = 0;
		outstanding = 1'b0;
		checkHold = 1'b1;
		for (int r = 0; r < encoderPkg::regCount; r++)
		begin
			loadCount[r] = 0;
			clearCount[r] = 0;
		end
		repeat (2) advanceCycle();
		frameDone = 1'b1;                             // Half an analysis window
		advanceCycle();
		frameDone = 1'b0;
		repeat (3)
		begin
			@(negedge clock);
			checkValue(32'(stageStart), 32'd0, "no stage start after one frameDone");
		end
		advanceCycle();
		frameDone = 1'b1;
		advanceCycle();
		frameDone = 1'b0;
		@(negedge clock);
		checkValue(32'(stageStart), 32'(maskOf(encoderPkg::stageAutocorr)),
			"autocorr start after the second frameDone");
		if (scenarioAbortRow[s] < 0)
			finishFrame();
		else
			abortFrame(scenarioAbortRow[s]);
	endtask

	initial
	begin
		clock = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		divErr = 1'b0;
		frameDone = 1'b0;
		randomDelays = 1'b0;
		rowIdx = 0;
		completeCount = 0;
		framesCompleted = 0;
		outstanding = 1'b0;
		checkHold = 1'b0;
		heldStep = '0;
		heldStage = encoderPkg::stageAutocorr;
		for (int r = 0; r < encoderPkg::regCount; r++)
		begin
			loadCount[r] = 0;
			clearCount[r] = 0;
		end
		buildTables();
		repeat (8) @(posedge clock);
		#1;
		reset = 1'b0;
		repeat (4)
		begin
			@(negedge clock);
			checkValue(32'(stageStart), 32'd0, "stageStart after reset");
			checkValue(32'(regLoad), 32'd0, "regLoad after reset");
			checkValue(32'(frameComplete), 32'd0, "frameComplete after reset");
			checkValue(32'(mathMuxSel), 32'd0, "mux step after reset");
			checkValue(32'(regClear), 32'(allClear), "regClear after reset");
		end
		for (int s = 0; s < scenarioCount; s++)
			runFrame(s);
		repeat (4) @(posedge clock);
		if (framesCompleted == framesExpected)
		begin
			$display("Verification passed");
			$finish;
		end
		else
		begin
			$display("CHECK FAILED at time %0t: frameComplete pulses over the run (got %0d, expected %0d)",
				$time, framesCompleted, framesExpected);
			$display("Verification failed");
			$fatal(1, "stopping at first error");
		end
	end

endmodule

// File: verilog.f
logic/encoderPkg.sv
logic/frameArrivalGate.sv
logic/lpcAnalysisSequencer.sv
logic/subframeSequencer.sv
logic/encoderController.sv
verif/stageModel.sv
verif/encoderControllerTb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator and run; pass only if the testbench reports it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module encoderControllerTb \
	-Mdir obj_dir -o simv \
	&& ./obj_dir/simv | grep "Verification passed" \
	&& echo "Simulation PASSED" \
	|| { echo "Simulation FAILED"; exit 1; }
